//--- hdl/spi_axil_regs.sv
/* SPI master register block
   AXI-Lite slave channels, register file and FIFO strobes */
`timescale 1ns/1ps
`include "spi_master_config.svh"

module spi_axil_regs (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  spi_master_pkg::axil_addr_t s_axil_awaddr_i,
    input  logic                       s_axil_awvalid_i,
    output logic                       s_axil_awready_o,
    input  spi_master_pkg::spi_word_t  s_axil_wdata_i,
    input  spi_master_pkg::spi_strb_t  s_axil_wstrb_i,
    input  logic                       s_axil_wvalid_i,
    output logic                       s_axil_wready_o,
    output logic [1:0]                 s_axil_bresp_o,
    output logic                       s_axil_bvalid_o,
    input  logic                       s_axil_bready_i,
    input  spi_master_pkg::axil_addr_t s_axil_araddr_i,
    input  logic                       s_axil_arvalid_i,
    output logic                       s_axil_arready_o,
    output spi_master_pkg::spi_word_t  s_axil_rdata_o,
    output logic [1:0]                 s_axil_rresp_o,
    output logic                       s_axil_rvalid_o,
    input  logic                       s_axil_rready_i,
    input  logic                       tx_full_i,
    input  logic                       tx_empty_i,
    input  logic                       rx_full_i,
    input  logic                       rx_empty_i,
    input  spi_master_pkg::spi_word_t  rx_data_i,
    output logic                       tx_push_o,
    output spi_master_pkg::spi_word_t  tx_data_o,
    output logic                       rx_pop_o,
    output logic                       ctrl_clear_o,
    output logic                       enable_o,
    output logic                       loopback_o,
    output logic                       manual_ss_o,
    output spi_master_pkg::spi_prescale_t prescale_o,
    output spi_master_pkg::spi_width_t word_width_o,
    output spi_master_pkg::spi_ncs_t   slave_select_o
);
    import spi_master_pkg::*;

    // Implemented control bits: prescale, width, manual SS, enable, loop
    localparam spi_word_t CTRL_MASK = 32'hFFFF_FF23;

    logic       do_write;
    logic       do_read;
    axil_addr_t waddr;
    axil_addr_t raddr;
    spi_word_t  ctrl_q;
    spi_ncs_t   ss_q;
    spi_word_t  ctrl_merged;
    spi_word_t  ss_merged;
    spi_word_t  tx_merged;
    spi_word_t  rd_word;

    function automatic spi_word_t byte_merge(input spi_word_t old_w, input spi_word_t new_w,
                                             input spi_strb_t strb);
        spi_word_t res;
        res = old_w;
        for (int b = 0; b < $bits(spi_strb_t); b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Word-aligned register addresses
    assign waddr = {s_axil_awaddr_i[`SPI_AXIL_ADDR_WIDTH-1:2], 2'b00};
    assign raddr = {s_axil_araddr_i[`SPI_AXIL_ADDR_WIDTH-1:2], 2'b00};

    // A new write waits out the awready pulse of the previous one
    assign do_write = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_awready_o &&
                      (!s_axil_bvalid_o || s_axil_bready_i);
    assign do_read  = s_axil_arvalid_i && !s_axil_arready_o &&
                      (!s_axil_rvalid_o || s_axil_rready_i);

    assign ctrl_merged = byte_merge(ctrl_q, s_axil_wdata_i, s_axil_wstrb_i) & CTRL_MASK;
    assign ss_merged   = byte_merge({{($bits(spi_word_t) - $bits(spi_ncs_t)){1'b1}}, ss_q},
                                    s_axil_wdata_i, s_axil_wstrb_i);
    assign tx_merged   = byte_merge(tx_data_o, s_axil_wdata_i, s_axil_wstrb_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s_axil_awready_o <= 1'b0;
            s_axil_wready_o  <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
            tx_push_o        <= 1'b0;
            ctrl_clear_o     <= 1'b0;
            ctrl_q           <= `SPI_CTRL_RESET;
            ss_q             <= '1;
        end else begin
            s_axil_awready_o <= do_write;
            s_axil_wready_o  <= do_write;
            s_axil_bvalid_o  <= do_write || (s_axil_bvalid_o && !s_axil_bready_i);
            tx_push_o        <= do_write && (waddr == `SPI_REG_TXDATA);
            ctrl_clear_o     <= do_write && (waddr == `SPI_REG_CTRL);
            if (do_write && (waddr == `SPI_REG_CTRL)) begin
                ctrl_q <= ctrl_merged;
            end
            if (do_write && (waddr == `SPI_REG_SS)) begin
                ss_q <= ss_merged[$bits(spi_ncs_t)-1:0];
            end
        end
    end

    // Transmit word keeps unstrobed bytes from the previous write
    always_ff @(posedge clk) begin
        if (do_write && (waddr == `SPI_REG_TXDATA)) begin
            tx_data_o <= tx_merged;
        end
    end

    always_comb begin
        rd_word = '0;
        case (raddr)
            `SPI_REG_ID:     rd_word = `SPI_ID_VALUE;
            `SPI_REG_CTRL:   rd_word = ctrl_q;
            `SPI_REG_STATUS: rd_word[3:0] = {tx_full_i, tx_empty_i, rx_full_i, rx_empty_i};
            `SPI_REG_SS:     rd_word[$bits(spi_ncs_t)-1:0] = ss_q;
            `SPI_REG_RXDATA: rd_word = rx_data_i;
            default:         rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
            rx_pop_o         <= 1'b0;
        end else begin
            s_axil_arready_o <= do_read;
            s_axil_rvalid_o  <= do_read || (s_axil_rvalid_o && !s_axil_rready_i);
            rx_pop_o         <= do_read && (raddr == `SPI_REG_RXDATA) && !rx_empty_i;
        end
    end

    // Read data holds until the next accepted read
    always_ff @(posedge clk) begin
        if (do_read) begin
            s_axil_rdata_o <= rd_word;
        end
    end

    assign s_axil_bresp_o = 2'b00;
    assign s_axil_rresp_o = 2'b00;

    assign loopback_o     = ctrl_q[0];
    assign enable_o       = ctrl_q[1];
    assign manual_ss_o    = ctrl_q[5];
    assign word_width_o   = ctrl_q[15:8];
    assign prescale_o     = ctrl_q[31:16];
    assign slave_select_o = ss_q;

endmodule

//--- hdl/spi_master_axil.sv
/* SPI master with AXI-Lite register port
   Register block, transmit and receive FIFOs and the shift engine */
`timescale 1ns/1ps

module spi_master_axil (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  spi_master_pkg::axil_addr_t s_axil_awaddr_i,
    input  logic                       s_axil_awvalid_i,
    output logic                       s_axil_awready_o,
    input  spi_master_pkg::spi_word_t  s_axil_wdata_i,
    input  spi_master_pkg::spi_strb_t  s_axil_wstrb_i,
    input  logic                       s_axil_wvalid_i,
    output logic                       s_axil_wready_o,
    output logic [1:0]                 s_axil_bresp_o,
    output logic                       s_axil_bvalid_o,
    input  logic                       s_axil_bready_i,
    input  spi_master_pkg::axil_addr_t s_axil_araddr_i,
    input  logic                       s_axil_arvalid_i,
    output logic                       s_axil_arready_o,
    output spi_master_pkg::spi_word_t  s_axil_rdata_o,
    output logic [1:0]                 s_axil_rresp_o,
    output logic                       s_axil_rvalid_o,
    input  logic                       s_axil_rready_i,
    output logic                       spi_sclk_o,
    output logic                       spi_mosi_o,
    input  logic                       spi_miso_i,
    output spi_master_pkg::spi_ncs_t   spi_ncs_o
);
    import spi_master_pkg::*;

    // FIFO paths
    logic      tx_push;
    spi_word_t tx_data;
    logic      tx_pop;
    spi_word_t tx_head;
    logic      tx_full;
    logic      tx_empty;
    logic      rx_push;
    spi_word_t rx_word;
    logic      rx_pop;
    spi_word_t rx_head;
    logic      rx_full;
    logic      rx_empty;

    // Configuration from the control and slave-select registers
    logic          ctrl_clear;
    logic          enable;
    logic          loopback;
    logic          manual_ss;
    spi_prescale_t prescale;
    spi_width_t    word_width;
    spi_ncs_t      slave_select;

    spi_axil_regs regs_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .tx_full_i        (tx_full),
        .tx_empty_i       (tx_empty),
        .rx_full_i        (rx_full),
        .rx_empty_i       (rx_empty),
        .rx_data_i        (rx_head),
        .tx_push_o        (tx_push),
        .tx_data_o        (tx_data),
        .rx_pop_o         (rx_pop),
        .ctrl_clear_o     (ctrl_clear),
        .enable_o         (enable),
        .loopback_o       (loopback),
        .manual_ss_o      (manual_ss),
        .prescale_o       (prescale),
        .word_width_o     (word_width),
        .slave_select_o   (slave_select)
    );

    spi_word_fifo tx_fifo_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .clear_i     (ctrl_clear),
        .push_i      (tx_push),
        .push_data_i (tx_data),
        .pop_i       (tx_pop),
        .head_data_o (tx_head),
        .empty_o     (tx_empty),
        .full_o      (tx_full)
    );

    spi_word_fifo rx_fifo_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .clear_i     (ctrl_clear),
        .push_i      (rx_push),
        .push_data_i (rx_word),
        .pop_i       (rx_pop),
        .head_data_o (rx_head),
        .empty_o     (rx_empty),
        .full_o      (rx_full)
    );

    spi_shift_engine engine_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .clear_i        (ctrl_clear),
        .enable_i       (enable),
        .loopback_i     (loopback),
        .manual_ss_i    (manual_ss),
        .prescale_i     (prescale),
        .word_width_i   (word_width),
        .slave_select_i (slave_select),
        .tx_data_i      (tx_head),
        .tx_empty_i     (tx_empty),
        .spi_miso_i     (spi_miso_i),
        .tx_pop_o       (tx_pop),
        .rx_push_o      (rx_push),
        .rx_data_o      (rx_word),
        .spi_sclk_o     (spi_sclk_o),
        .spi_mosi_o     (spi_mosi_o),
        .spi_ncs_o      (spi_ncs_o)
    );

endmodule

//--- hdl/spi_master_pkg.sv
/* SPI master shared types
   Derived from the configuration macros */
`include "spi_master_config.svh"

package spi_master_pkg;

    // AXI-Lite address and data
    typedef logic [`SPI_AXIL_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [`SPI_DATA_WIDTH-1:0] spi_word_t;
    typedef logic [`SPI_DATA_WIDTH/8-1:0] spi_strb_t;

    // SCLK half period in clk cycles
    typedef logic [`SPI_PRESCALE_WIDTH-1:0] spi_prescale_t;

    // Bits per SPI word
    typedef logic [`SPI_WIDTH_FIELD_BITS-1:0] spi_width_t;

    // Active-low chip selects
    typedef logic [`SPI_NUM_SS-1:0] spi_ncs_t;

endpackage

//--- hdl/spi_shift_engine.sv
/* SPI mode 0 shift engine
   SCLK prescaler, MSB-first shifting, loopback and chip-select generation */
`timescale 1ns/1ps
`include "spi_master_config.svh"

module spi_shift_engine (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          clear_i,
    input  logic                          enable_i,
    input  logic                          loopback_i,
    input  logic                          manual_ss_i,
    input  spi_master_pkg::spi_prescale_t prescale_i,
    input  spi_master_pkg::spi_width_t    word_width_i,
    input  spi_master_pkg::spi_ncs_t      slave_select_i,
    input  spi_master_pkg::spi_word_t     tx_data_i,
    input  logic                          tx_empty_i,
    input  logic                          spi_miso_i,
    output logic                          tx_pop_o,
    output logic                          rx_push_o,
    output spi_master_pkg::spi_word_t     rx_data_o,
    output logic                          spi_sclk_o,
    output logic                          spi_mosi_o,
    output spi_master_pkg::spi_ncs_t      spi_ncs_o
);
    import spi_master_pkg::*;

    logic          busy_q;
    logic          sclk_q;
    spi_prescale_t half_cnt;
    spi_prescale_t presc_eff;
    logic [5:0]    width_eff;
    logic [5:0]    bits_left;
    spi_word_t     tx_shift;
    spi_word_t     rx_shift;
    logic          mosi_int;
    logic          miso_sel;
    logic          half_done;
    spi_ncs_t      ncs_int;

    // Zero prescale and zero width act as 1, widths clamp at 32
    assign presc_eff = (prescale_i == '0) ? spi_prescale_t'(1) : prescale_i;
    assign width_eff = (word_width_i == '0) ? 6'd1 :
                       (word_width_i > 8'd32) ? 6'd32 : word_width_i[5:0];

    assign tx_pop_o  = !busy_q && enable_i && !tx_empty_i && !clear_i;
    assign half_done = (half_cnt == presc_eff - spi_prescale_t'(1));
    assign mosi_int  = busy_q && tx_shift[`SPI_DATA_WIDTH-1];
    assign miso_sel  = loopback_i ? mosi_int : spi_miso_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            busy_q    <= 1'b0;
            sclk_q    <= 1'b0;
            half_cnt  <= '0;
            rx_push_o <= 1'b0;
        end else begin
            rx_push_o <= 1'b0;
            if (tx_pop_o) begin
                busy_q   <= 1'b1;
                half_cnt <= '0;
            end else if (busy_q) begin
                half_cnt <= half_done ? '0 : half_cnt + spi_prescale_t'(1);
                if (half_done) begin
                    sclk_q <= !sclk_q;
                    // Last falling edge ends the word
                    if (sclk_q && bits_left == 6'd1) begin
                        busy_q    <= 1'b0;
                        rx_push_o <= 1'b1;
                    end
                end
            end
        end
    end

    // Datapath: load on start, sample on rising, shift on falling
    always_ff @(posedge clk) begin
        if (tx_pop_o) begin
            tx_shift  <= tx_data_i << (6'd32 - width_eff);
            rx_shift  <= '0;
            bits_left <= width_eff;
        end else if (busy_q && half_done) begin
            if (!sclk_q) begin
                rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], miso_sel};
            end else begin
                tx_shift  <= tx_shift << 1;
                bits_left <= bits_left - 6'd1;
                if (bits_left == 6'd1) begin
                    rx_data_o <= rx_shift;
                end
            end
        end
    end

    // Highest selected line wins
    always_comb begin
        ncs_int = '1;
        for (int i = 0; i < `SPI_NUM_SS; i++) begin
            if (!slave_select_i[i]) begin
                ncs_int    = '1;
                ncs_int[i] = !(manual_ss_i || busy_q);
            end
        end
    end

    assign spi_sclk_o = enable_i && sclk_q;
    assign spi_mosi_o = enable_i && mosi_int;
    assign spi_ncs_o  = enable_i ? ncs_int : '1;

endmodule

//--- hdl/spi_word_fifo.sv
/* Synchronous first-word-fall-through FIFO of SPI words
   with full and empty levels and a synchronous clear */
`timescale 1ns/1ps
`include "spi_master_config.svh"

module spi_word_fifo (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      clear_i,
    input  logic                      push_i,
    input  spi_master_pkg::spi_word_t push_data_i,
    input  logic                      pop_i,
    output spi_master_pkg::spi_word_t head_data_o,
    output logic                      empty_o,
    output logic                      full_o
);
    import spi_master_pkg::*;

    localparam int DEPTH = `SPI_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    spi_word_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push_ok;
    logic             pop_ok;

    // Overflow and underflow requests are ignored
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_ok);
            rd_ptr <= rd_ptr + PTR_W'(pop_ok);
            count  <= count + (PTR_W+1)'(push_ok) - (PTR_W+1)'(pop_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    assign head_data_o = mem[rd_ptr];
    assign empty_o     = (count == '0);
    assign full_o      = (count == (PTR_W+1)'(DEPTH));

endmodule

//--- include/spi_master_config.svh
/* SPI master configuration
   Bus widths, register map, reset values and FIFO depth */
`ifndef SPI_MASTER_CONFIG_SVH
`define SPI_MASTER_CONFIG_SVH

// Bus and datapath widths
`define SPI_AXIL_ADDR_WIDTH   8
`define SPI_DATA_WIDTH        32
`define SPI_NUM_SS            4
`define SPI_FIFO_DEPTH        8
`define SPI_PRESCALE_WIDTH    16
`define SPI_WIDTH_FIELD_BITS  8

// Register offsets
`define SPI_REG_ID      8'h00
`define SPI_REG_CTRL    8'h20
`define SPI_REG_STATUS  8'h28
`define SPI_REG_SS      8'h2C
`define SPI_REG_TXDATA  8'h30
`define SPI_REG_RXDATA  8'h34

// Fixed ID word and control reset (prescale 4, width 8, manual select)
`define SPI_ID_VALUE    32'h294EC100
`define SPI_CTRL_RESET  32'h00040820

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module spi_master_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vspi_master_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sources.f
+incdir+include
hdl/spi_master_pkg.sv
hdl/spi_axil_regs.sv
hdl/spi_word_fifo.sv
hdl/spi_shift_engine.sv
hdl/spi_master_axil.sv
verification/spi_master_properties.sv
verification/spi_tb_clock.sv
verification/spi_master_tb.sv

//--- verification/spi_master_properties.sv
/* SPI master protocol properties
   AXI-Lite response stability, one-hot chip select and SCLK gating */
`timescale 1ns/1ps

module spi_master_properties (
    input logic        clk,
    input logic        rst_n_i,
    input logic        s_axil_bvalid_o,
    input logic        s_axil_bready_i,
    input logic        s_axil_rvalid_o,
    input logic        s_axil_rready_i,
    input logic [31:0] s_axil_rdata_o,
    input logic [3:0]  spi_ncs_o,
    input logic        spi_sclk_o,
    input logic        enable_i
);

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o))
        else $error("rvalid or rdata changed before rready");

    ncs_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $countones(~spi_ncs_o) <= 1)
        else $error("more than one chip select low");

    // Engine stays idle while disabled, so SCLK also starts low on enable
    sclk_gated: assert property (@(posedge clk) disable iff (!rst_n_i)
        !enable_i |-> !spi_sclk_o ##1 !spi_sclk_o)
        else $error("SCLK active while disabled or right after enable");

endmodule

bind spi_master_axil spi_master_properties props_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .s_axil_bvalid_o (s_axil_bvalid_o),
    .s_axil_bready_i (s_axil_bready_i),
    .s_axil_rvalid_o (s_axil_rvalid_o),
    .s_axil_rready_i (s_axil_rready_i),
    .s_axil_rdata_o  (s_axil_rdata_o),
    .spi_ncs_o       (spi_ncs_o),
    .spi_sclk_o      (spi_sclk_o),
    .enable_i        (enable)
);

//--- verification/spi_master_tb.sv
/* SPI master testbench
   Random register and transfer tests against a reference model */
`timescale 1ns/1ps

module spi_master_tb;
    import spi_master_pkg::*;

    logic       clk;
    logic       rst_n;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    spi_word_t  wdata;
    spi_strb_t  wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    spi_word_t  rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_miso = 1'b0;
    spi_ncs_t   spi_ncs;

    integer seed = 96;
    int     errors = 0;
    int     checks = 0;
    int     test_start_errors = 0;

    // Register model
    logic [31:0] ctrl_model;
    logic [3:0]  ss_model;

    // SPI slave model state
    logic [31:0] slave_tx;
    logic [31:0] miso_shift;
    logic [31:0] mosi_cap;
    int          load_req = 0;
    int          load_seen = 0;
    logic        sclk_s = 1'b0;
    logic        mosi_s = 1'b0;
    logic        sclk_d = 1'b0;

    spi_tb_clock clock_i (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    spi_master_axil dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready),
        .spi_sclk_o       (spi_sclk),
        .spi_mosi_o       (spi_mosi),
        .spi_miso_i       (spi_miso),
        .spi_ncs_o        (spi_ncs)
    );

    // Slave model samples the bus mid-cycle
    always @(negedge clk) begin
        sclk_s = spi_sclk;
        mosi_s = spi_mosi;
    end

    // Capture MOSI after rising SCLK, shift MISO after falling SCLK
    always @(posedge clk) begin
        sclk_d <= sclk_s;
        if (load_req != load_seen) begin
            load_seen  <= load_req;
            miso_shift <= slave_tx;
            spi_miso   <= slave_tx[31];
            mosi_cap   <= 32'h0;
        end else begin
            if (sclk_s && !sclk_d) begin
                mosi_cap <= {mosi_cap[30:0], mosi_s};
            end
            if (!sclk_s && sclk_d) begin
                miso_shift <= {miso_shift[30:0], 1'b0};
                spi_miso   <= miso_shift[30];
            end
        end
    end

    function automatic logic [31:0] byte_update(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] width_mask(input int width);
        if (width >= 32) begin
            return 32'hFFFF_FFFF;
        end
        return (32'h1 << width) - 32'h1;
    endfunction

    // Search from the top line down for the first zero
    function automatic logic [3:0] expected_ncs(input logic [3:0] ss);
        logic [3:0] res;
        res = 4'hF;
        for (int i = 3; i >= 0; i--) begin
            if (!ss[i] && res == 4'hF) begin
                res[i] = 1'b0;
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int waited;
        int stall;
        waited = 0;
        // Random back-pressure on the write response
        stall = $unsigned($random(seed)) % 3;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= (stall == 0);
        do begin
            @(negedge clk);
            waited++;
        end while (!(awready && wready && bvalid) && waited < 50);
        if (!(awready && wready && bvalid)) begin
            $display("write to 0x%h was never accepted", addr);
            errors++;
        end
        check_value("bresp", {30'h0, bresp}, 32'h0);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (bvalid && waited < 50);
        if (bvalid) begin
            $display("write response for 0x%h was never released", addr);
            errors++;
        end
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int waited;
        int stall;
        waited = 0;
        // Random back-pressure on the read data
        stall = $unsigned($random(seed)) % 3;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (stall == 0);
        do begin
            @(negedge clk);
            waited++;
        end while (!(arready && rvalid) && waited < 50);
        if (!(arready && rvalid)) begin
            $display("read from 0x%h got no response", addr);
            errors++;
        end
        check_value("rresp", {30'h0, rresp}, 32'h0);
        data = rdata;
        @(posedge clk);
        arvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (rvalid && waited < 50);
        if (rvalid) begin
            $display("read data for 0x%h was never released", addr);
            errors++;
        end
    endtask

    task automatic wait_rx_data();
        logic [31:0] status;
        int tries;
        tries = 0;
        do begin
            axil_read(8'h28, status);
            tries++;
        end while (status[0] && tries < 500);
        if (status[0]) begin
            $display("receive FIFO stayed empty after a transfer");
            errors++;
        end
    endtask

    task automatic wait_ncs_active(input logic want_low);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (((spi_ncs != 4'hF) != want_low) && waited < 500);
        if ((spi_ncs != 4'hF) != want_low) begin
            $display("chip select did not change as expected");
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        #2_000_000;
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] data;
        logic [31:0] tx;
        logic [3:0]  strb;
        int          width;
        int          presc;
        int          waited;

        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        ctrl_model = 32'h0004_0820;
        ss_model   = 4'hF;
        slave_tx   = 32'h0;
        waited     = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
        end

        // Reset values
        axil_read(8'h00, rd);
        check_value("rdata id", rd, 32'h294E_C100);
        axil_read(8'h20, rd);
        check_value("rdata ctrl", rd, ctrl_model);
        axil_read(8'h28, rd);
        check_value("rdata status", rd, 32'h5);
        axil_read(8'h2C, rd);
        check_value("rdata ss", rd, 32'hF);
        finish_test("reset values");

        // Random strobed register writes
        for (int i = 0; i < 24; i++) begin
            data = $random(seed);
            strb = 4'($random(seed));
            if (i % 2 == 0) begin
                axil_write(8'h20, data, strb);
                ctrl_model = byte_update(ctrl_model, data, strb) & 32'hFFFF_FF23;
                axil_read(8'h20, rd);
                check_value("rdata ctrl", rd, ctrl_model);
                check_value("rdata ctrl reserved", rd & 32'hDC, 32'h0);
            end else begin
                axil_write(8'h2C, data, strb);
                rd = byte_update({28'hFFF_FFFF, ss_model}, data, strb);
                ss_model = rd[3:0];
                axil_read(8'h2C, rd);
                check_value("rdata ss", rd, {28'h0, ss_model});
            end
        end
        finish_test("register writes");

        // Loopback transfers
        for (int i = 0; i < 12; i++) begin
            width = 1 + ($unsigned($random(seed)) % 32);
            presc = 1 + ($unsigned($random(seed)) % 3);
            axil_write(8'h20, (presc << 16) | (width << 8) | 32'h23, 4'hF);
            tx = $random(seed);
            axil_write(8'h30, tx, 4'hF);
            wait_rx_data();
            axil_read(8'h34, rd);
            check_value("rdata loopback", rd, tx & width_mask(width));
        end
        finish_test("loopback");

        // External transfers against the slave model
        for (int i = 0; i < 10; i++) begin
            width = 1 + ($unsigned($random(seed)) % 32);
            presc = 2 + ($unsigned($random(seed)) % 2);
            axil_write(8'h20, (presc << 16) | (width << 8) | 32'h22, 4'hF);
            slave_tx = $random(seed);
            slave_tx = slave_tx << (32 - width);
            load_req++;
            tx = $random(seed);
            axil_write(8'h30, tx, 4'hF);
            wait_rx_data();
            axil_read(8'h34, rd);
            check_value("rdata miso", rd, slave_tx >> (32 - width));
            check_value("mosi", mosi_cap & width_mask(width), tx & width_mask(width));
        end
        finish_test("external");

        // FIFO full with the engine disabled, then clear
        axil_write(8'h20, 32'h0004_0820, 4'hF);
        for (int i = 0; i < 8; i++) begin
            axil_write(8'h30, $random(seed), 4'hF);
        end
        axil_read(8'h28, rd);
        check_value("rdata status full", rd, 32'h9);
        axil_write(8'h20, 32'h0004_0820, 4'hF);
        axil_read(8'h28, rd);
        check_value("rdata status cleared", rd, 32'h5);
        finish_test("fifo status");

        // Chip select behavior
        ss_model = 4'($random(seed));
        if (ss_model == 4'hF) begin
            ss_model = 4'hE;
        end
        axil_write(8'h2C, {28'h0, ss_model}, 4'h1);
        @(negedge clk);
        check_value("spi_ncs disabled", {28'h0, spi_ncs}, 32'hF);
        axil_write(8'h20, 32'h0002_0822, 4'hF);
        @(negedge clk);
        check_value("spi_ncs manual", {28'h0, spi_ncs}, {28'h0, expected_ncs(ss_model)});
        axil_write(8'h20, 32'h0002_0803, 4'hF);
        @(negedge clk);
        check_value("spi_ncs auto idle", {28'h0, spi_ncs}, 32'hF);
        axil_write(8'h30, $random(seed), 4'hF);
        wait_ncs_active(1'b1);
        check_value("spi_ncs auto busy", {28'h0, spi_ncs}, {28'h0, expected_ncs(ss_model)});
        wait_rx_data();
        @(negedge clk);
        check_value("spi_ncs auto done", {28'h0, spi_ncs}, 32'hF);
        finish_test("chip select");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/spi_tb_clock.sv
/* Testbench clock and reset source
   4 ns clock, active-low reset held for 3 cycles */
`timescale 1ns/1ps

module spi_tb_clock (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk);
        rst_n_o <= 1'b1;
    end

endmodule
